//--- logic/div_pkg.sv
// Divide unit shared definitions
package div_pkg;

    //////////////////////////////////////////////////
    // Data path widths
    //////////////////////////////////////////////////

    // Width of dividend, divisor and both results.
    localparam int div_width = 32;

    // Index width for a leading-one position within a word.
    localparam int msb_width = $clog2(div_width);

    //////////////////////////////////////////////////
    // Operation codes
    //////////////////////////////////////////////////

    localparam int op_width = 2; // Two bits select one of four ops.

    // Signed quotient.
    localparam logic [op_width-1:0] op_div = 2'd0;

    // Unsigned quotient.
    localparam logic [op_width-1:0] op_divu = 2'd1;

    // Signed remainder, sign follows the dividend.
    localparam logic [op_width-1:0] op_rem = 2'd2;

    // Unsigned remainder.
    localparam logic [op_width-1:0] op_remu = 2'd3;

endpackage

//--- logic/div_core_if.sv
// Divider core request and result bus
`timescale 1ns/10ps

interface div_core_if;

    //////////////////////////////////////////////////
    // Request side, driven by the control block
    //////////////////////////////////////////////////
    logic                          start;    // Load operands, one cycle.
    logic                          ack;      // Result consumed, one cycle.
    logic [div_pkg::div_width-1:0] dividend; // Magnitude, valid on start.
    logic [div_pkg::div_width-1:0] divisor;  // Magnitude, never zero.

    //////////////////////////////////////////////////
    // Result side, driven by the divider core
    //////////////////////////////////////////////////
    logic [div_pkg::div_width-1:0] quotient;  // Held while complete.
    logic [div_pkg::div_width-1:0] remainder; // Held while complete.
    logic                          complete;  // Level until ack.

    // Divider core view.
    modport core (
        input  start, ack, dividend, divisor,
        output quotient, remainder, complete
    );

    // Control block view.
    modport ctrl (
        output start, ack, dividend, divisor,
        input  quotient, remainder, complete
    );

endinterface

//--- logic/msb_naive.sv
// Leading-one position detector
`timescale 1ns/10ps

module msb_naive #(
    parameter int width = div_pkg::div_width, // Input word width.
    parameter int msb_w = div_pkg::msb_width  // Position width, log2 of width.
) (
    input  logic [width-1:0] msb_input,
    output logic [msb_w-1:0] msb
);

    //////////////////////////////////////////////////
    // Priority scan
    //////////////////////////////////////////////////

    // Later hits overwrite earlier ones, so the highest set bit wins.
    // An all-zero word leaves the default of 0 in place.
    always_comb begin
        msb = '0; // Zero input maps to position 0.
        for (int i = 0; i < width; i++) begin
            if (msb_input[i]) begin
                msb = msb_w'(i); // Record this set bit.
            end
        end
    end

endmodule

//--- logic/div_quick_naive.sv
// Early-terminating shift-subtract divider
`timescale 1ns/10ps

module div_quick_naive #(
    parameter int width = div_pkg::div_width, // Word width, power of two.
    parameter int msb_w = div_pkg::msb_width  // Leading-one index width.
) (
    input logic       clk,
    input logic       rst,
    div_core_if.core  div
);

    logic             running;    // Iteration in progress.
    logic             terminate;  // Remainder dropped below divisor.
    logic             complete_r; // Result ready, held until ack.

    logic [width-1:0] quo_r;      // Partial quotient.
    logic [width-1:0] rem_r;      // Partial remainder.
    logic [width-1:0] dvs_r;      // Divisor captured on start.

    logic [msb_w-1:0] rem_msb;    // Leading one of remainder.
    logic [msb_w-1:0] dvs_msb;    // Leading one of divisor.
    logic [msb_w-1:0] msb_delta;  // Alignment distance.

    logic [width-1:0] dvs_sh1;    // Divisor aligned to remainder.
    logic [width-1:0] dvs_sh2;    // One place less, for the borrow case.
    logic [width:0]   diff1;      // Extra bit catches the borrow.
    logic [width-1:0] diff2;      // Fallback difference.
    logic [width-1:0] qbit1;      // Quotient bit for full alignment.
    logic [width-1:0] qbit2;      // Quotient bit one place lower.
    logic [width-1:0] next_rem;
    logic [width-1:0] next_quo;

    //////////////////////////////////////////////////
    // Alignment and subtraction
    //////////////////////////////////////////////////

    msb_naive #(.width(width), .msb_w(msb_w)) u_msb_rem (
        .msb_input (rem_r),
        .msb       (rem_msb)
    );

    msb_naive #(.width(width), .msb_w(msb_w)) u_msb_dvs (
        .msb_input (dvs_r),
        .msb       (dvs_msb)
    );

    // Remainder is at least the divisor while iterating, so no wrap.
    assign msb_delta = rem_msb - dvs_msb;

    assign dvs_sh1 = dvs_r << msb_delta;                 // Shift into place.
    assign dvs_sh2 = {1'b0, dvs_sh1[width-1:1]};         // Back off one bit.
    assign diff1   = {1'b0, rem_r} - {1'b0, dvs_sh1};    // Top bit is borrow.
    assign diff2   = rem_r - dvs_sh2;                    // Always fits.

    assign qbit1 = {{(width-1){1'b0}}, 1'b1} << msb_delta;
    assign qbit2 = {1'b0, qbit1[width-1:1]};

    // A borrow means the aligned divisor overshot by one place.
    assign next_rem = diff1[width] ? diff2 : diff1[width-1:0];
    assign next_quo = quo_r | (diff1[width] ? qbit2 : qbit1);

    assign terminate = (rem_r < dvs_r); // Nothing more to subtract.

    //////////////////////////////////////////////////
    // Control flags
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            running    <= 1'b0;
            complete_r <= 1'b0;
        end else if (div.start) begin
            running    <= 1'b1; // New operation clears old result.
            complete_r <= 1'b0;
        end else if (running && terminate) begin
            running    <= 1'b0; // Done, hold result.
            complete_r <= 1'b1;
        end else if (div.ack) begin
            complete_r <= 1'b0; // Consumer took it.
        end
    end

    //////////////////////////////////////////////////
    // Data registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (div.start) begin
            quo_r <= '0;           // Fresh quotient.
            rem_r <= div.dividend; // Remainder starts as dividend.
            dvs_r <= div.divisor;
        end else if (running && !terminate) begin
            quo_r <= next_quo;     // At least one bit per cycle.
            rem_r <= next_rem;
        end
    end

    assign div.quotient  = quo_r;
    assign div.remainder = rem_r;
    assign div.complete  = complete_r;

endmodule

//--- logic/div_sign_ctrl.sv
// Divide request and sign control
`timescale 1ns/10ps

module div_sign_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                issue,  // Request pulse.
    input  logic [div_pkg::op_width-1:0]        op,
    input  logic [div_pkg::div_width-1:0]       rs1,    // Dividend.
    input  logic [div_pkg::div_width-1:0]       rs2,    // Divisor.
    output logic                                busy,
    output logic                                done,
    output logic [div_pkg::div_width-1:0]       result,
    div_core_if.ctrl                            core
);

    localparam int w = div_pkg::div_width;

    logic         accept;      // Issue taken this cycle.
    logic         is_signed;   // Op treats operands as signed.
    logic         div_zero;    // Divisor is zero.
    logic         rs1_neg;     // Signed and dividend negative.
    logic         rs2_neg;     // Signed and divisor negative.
    logic [w-1:0] rs1_mag;
    logic [w-1:0] rs2_mag;

    logic [div_pkg::op_width-1:0] op_r;
    logic         signed_r;    // Held signed flag.
    logic         rem_sel;     // Remainder wanted.
    logic         quo_neg;     // Quotient sign.
    logic         rem_neg;     // Remainder sign, follows dividend.
    logic [w-1:0] dvd_mag;     // Dividend magnitude.
    logic [w-1:0] dvs_mag;     // Divisor magnitude.

    logic         start_r;
    logic         bypass_pend; // Zero divisor, answer next edge.
    logic         core_wait;   // Core running our request.
    logic         core_ack;
    logic         finish;      // Result ready this cycle.

    logic [w-1:0] raw_quo;
    logic [w-1:0] raw_rem;
    logic [w-1:0] raw_res;
    logic         negate;
    logic [w-1:0] fixed_res;   // Sign corrected result.

    //////////////////////////////////////////////////
    // Request decode
    //////////////////////////////////////////////////

    assign accept    = issue && !busy; // Issue while busy is dropped.
    assign is_signed = (op == div_pkg::op_div) || (op == div_pkg::op_rem);
    assign div_zero  = (rs2 == '0);

    assign rs1_neg = is_signed && rs1[w-1];
    assign rs2_neg = is_signed && rs2[w-1];
    assign rs1_mag = rs1_neg ? -rs1 : rs1; // Most negative stays put.
    assign rs2_mag = rs2_neg ? -rs2 : rs2;

    // Operands and sign flags, no reset needed.
    always_ff @(posedge clk) begin
        if (accept) begin
            op_r     <= op;
            signed_r <= is_signed;
            quo_neg  <= (rs1[w-1] ^ rs2[w-1]) && !div_zero; // All ones unsigned.
            rem_neg  <= rs1[w-1];
            dvd_mag  <= rs1_mag;
            dvs_mag  <= rs2_mag;
        end
    end

    assign rem_sel = (op_r == div_pkg::op_rem) || (op_r == div_pkg::op_remu);

    //////////////////////////////////////////////////
    // Sequencing
    //////////////////////////////////////////////////

    assign core_ack = core_wait && core.complete; // First cycle it is seen.
    assign finish   = bypass_pend || core_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            done        <= 1'b0;
            start_r     <= 1'b0;
            bypass_pend <= 1'b0;
            core_wait   <= 1'b0;
        end else begin
            start_r     <= accept && !div_zero; // Core kicked one cycle later.
            bypass_pend <= accept && div_zero;  // Skip core entirely.
            done        <= finish;
            if (accept) begin
                busy <= 1'b1;
            end else if (finish) begin
                busy <= 1'b0;
            end
            if (accept && !div_zero) begin
                core_wait <= 1'b1;
            end else if (core_ack) begin
                core_wait <= 1'b0;
            end
        end
    end

    assign core.start    = start_r;
    assign core.ack      = core_ack;
    assign core.dividend = dvd_mag;
    assign core.divisor  = dvs_mag;

    //////////////////////////////////////////////////
    // Result select and sign fix
    //////////////////////////////////////////////////

    // By zero, quotient is all ones and remainder rebuilds rs1.
    assign raw_quo = bypass_pend ? '1 : core.quotient;
    assign raw_rem = bypass_pend ? dvd_mag : core.remainder;
    assign raw_res = rem_sel ? raw_rem : raw_quo;

    assign negate    = signed_r && (rem_sel ? rem_neg : quo_neg);
    assign fixed_res = negate ? -raw_res : raw_res; // Overflow case falls out.

    // Result holds from done until the next finish.
    always_ff @(posedge clk) begin
        if (finish) begin
            result <= fixed_res;
        end
    end

endmodule

//--- logic/div_unit.sv
// Integer divide unit top level
`timescale 1ns/10ps

module div_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          issue,  // One cycle request.
    input  logic [div_pkg::op_width-1:0]  op,     // DIV, DIVU, REM, REMU.
    input  logic [div_pkg::div_width-1:0] rs1,    // Dividend.
    input  logic [div_pkg::div_width-1:0] rs2,    // Divisor.
    output logic                          busy,   // Request in flight.
    output logic                          done,   // One cycle result strobe.
    output logic [div_pkg::div_width-1:0] result
);

    //////////////////////////////////////////////////
    // Control to core bus
    //////////////////////////////////////////////////

    div_core_if core_bus ();

    //////////////////////////////////////////////////
    // Sign handling and sequencing
    //////////////////////////////////////////////////

    div_sign_ctrl u_ctrl (
        .clk    (clk),
        .rst    (rst),
        .issue  (issue),
        .op     (op),
        .rs1    (rs1),
        .rs2    (rs2),
        .busy   (busy),
        .done   (done),
        .result (result),
        .core   (core_bus.ctrl)
    );

    //////////////////////////////////////////////////
    // Unsigned magnitude divider
    //////////////////////////////////////////////////

    div_quick_naive u_core (
        .clk (clk),
        .rst (rst),
        .div (core_bus.core) // Default width matches the bus.
    );

endmodule

//--- tb/div_unit_sva.sv
// Divide control strobe checks
`timescale 1ns/10ps

module div_unit_sva (
    input logic clk,
    input logic rst,
    input logic issue,     // Request pulse.
    input logic busy,
    input logic done,
    input logic start,     // Core load strobe.
    input logic ack,       // Core result taken.
    input logic complete   // Core result level.
);

    //////////////////////////////////////////////////
    // Strobe rules
    //////////////////////////////////////////////////

    done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    start_pulse: assert property (@(posedge clk) disable iff (rst) start |=> !start)
        else $error("core start stayed high for more than one cycle");

    ack_pulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("core ack stayed high for more than one cycle");

    // Ack hands the result back and drops complete.
    ack_clears: assert property (@(posedge clk) disable iff (rst) ack |=> !complete)
        else $error("core complete still high after ack");

    // Idle until a request arrives.
    busy_idle: assert property (@(posedge clk) disable iff (rst) !busy && !issue |=> !busy)
        else $error("busy rose without an issue");

endmodule

bind div_sign_ctrl div_unit_sva u_sva (
    .clk      (clk),
    .rst      (rst),
    .issue    (issue),
    .busy     (busy),
    .done     (done),
    .start    (core.start),
    .ack      (core.ack),
    .complete (core.complete)
);

//--- tb/div_unit_tb.sv
// Divide unit testbench
`timescale 1ns/10ps

module div_unit_tb;

    localparam int done_timeout = 64; // Cycles allowed per request.

    logic                          clk;
    logic                          rst;
    logic                          issue;
    logic [div_pkg::op_width-1:0]  op;
    logic [div_pkg::div_width-1:0] rs1;
    logic [div_pkg::div_width-1:0] rs2;
    logic                          busy;
    logic                          done;
    logic [div_pkg::div_width-1:0] result;

    logic [31:0] lfsr_state = 32'hffa0; // Stimulus seed.
    logic [31:0] exp_q[$];              // Expected results in issue order.
    logic [31:0] exp_val;
    logic [31:0] edges[8];              // Chosen corner operands.
    int          error_count = 0;
    int          check_count = 0;
    int          done_count  = 0;
    int          test_num    = 0;
    int          test_base   = 0;

    div_unit UUT (
        .clk    (clk),
        .rst    (rst),
        .issue  (issue),
        .op     (op),
        .rs1    (rs1),
        .rs2    (rs2),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    always #20 clk = ~clk; // 40 ns period.

    //////////////////////////////////////////////////
    // Stimulus and reference helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // Galois taps.
    endfunction

    task automatic rand_word(input int nbits, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state); // One step per bit.
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    // RV32M rules, written from the ISA definition.
    function automatic logic [31:0] ref_result(input logic [1:0] op_code,
                                               input logic [31:0] a,
                                               input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic               ovf;
        logic [31:0]        res;
        sa  = a;
        sb  = b;
        ovf = (a == 32'h80000000) && (b == 32'hffffffff); // Signed overflow.
        if (b == '0) begin
            res = (op_code == div_pkg::op_div || op_code == div_pkg::op_divu) ? '1 : a;
        end else if (op_code == div_pkg::op_divu) begin
            res = a / b;
        end else if (op_code == div_pkg::op_remu) begin
            res = a % b;
        end else if (ovf) begin
            res = (op_code == div_pkg::op_div) ? a : '0;
        end else if (op_code == div_pkg::op_div) begin
            res = sa / sb; // Truncates toward zero.
        end else begin
            res = sa % sb; // Sign of the dividend.
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual,
                     expected);
        end
    endtask

    task automatic send_req(input logic [1:0] op_code, input logic [31:0] a,
                            input logic [31:0] b, input logic [31:0] expected);
        @(posedge clk);
        issue <= 1'b1;
        op    <= op_code;
        rs1   <= a;
        rs2   <= b;
        exp_q.push_back(expected);
        @(posedge clk); // Accepting edge.
        issue <= 1'b0;
    endtask

    // Latency counts edges after the accepting edge.
    task automatic wait_done(output int lat);
        int cyc;
        lat = -1;
        cyc = 0;
        while (lat < 0 && cyc < done_timeout) begin
            @(negedge clk);
            if (done) begin
                lat = cyc;
            end
            cyc++;
        end
        if (lat < 0) begin
            error_count++;
            $display("Timeout at %0t ns: no done within %0d cycles of the request", $time,
                     done_timeout);
            exp_q.delete(); // Drop the lost result.
        end
    endtask

    task automatic end_test(input string name);
        @(posedge clk); // Let the last compare settle.
        test_num++;
        $display("Test %0d, %s: %0d errors", test_num, name, error_count - test_base);
        test_base = error_count;
    endtask

    task automatic random_run(input logic is_signed, input int count);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [1:0]  code;
        int          lat;
        for (int i = 0; i < count; i++) begin
            rand_word(32, a);
            rand_word(32, b);
            rand_word(5, r);
            b = b >> r[4:0]; // Spread the quotient sizes.
            if (is_signed) begin
                rand_word(1, r);
                if (r[0]) begin
                    b = -b;
                end
            end
            if (i % 10 == 0) begin
                rand_word(3, r);
                a = edges[r[2:0]];
                rand_word(3, r);
                b = edges[r[2:0]];
            end
            rand_word(1, r);
            if (is_signed) begin
                code = r[0] ? div_pkg::op_rem : div_pkg::op_div;
            end else begin
                code = r[0] ? div_pkg::op_remu : div_pkg::op_divu;
            end
            send_req(code, a, b, ref_result(code, a, b));
            wait_done(lat);
        end
    endtask

    //////////////////////////////////////////////////
    // Result compare
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst && done) begin
            done_count++;
            if (exp_q.size() == 0) begin
                error_count++;
                $display("Unexpected done at %0t ns with no request pending", $time);
            end else begin
                exp_val = exp_q.pop_front();
                check_value("result", result, exp_val);
                check_value("busy", {31'b0, busy}, 32'd0); // Idle with done.
            end
        end
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        int          lat;
        int          base_done;
        logic [31:0] dvd[4];
        logic [1:0]  code;
        clk   = 1'b0;
        rst   = 1'b1;
        issue = 1'b0;
        op    = '0;
        rs1   = '0;
        rs2   = '0;
        edges = '{32'h0, 32'h1, 32'h7, 32'h7fffffff, 32'h80000000, 32'hffffffff,
                  32'hfffffffe, 32'h00010000};
        dvd   = '{32'h12345678, 32'hfffffff9, 32'h80000000, 32'h0};
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < 8; i++) begin
            @(negedge clk); // Idle after reset.
            check_value("busy", {31'b0, busy}, 32'd0);
            check_value("done", {31'b0, done}, 32'd0);
        end
        end_test("idle after reset");

        random_run(1'b0, 200);
        end_test("random DIVU and REMU");

        random_run(1'b1, 200);
        end_test("random DIV and REM");

        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < 4; k++) begin
                code = 2'(k);
                send_req(code, dvd[i], 32'h0,
                         (code == div_pkg::op_div || code == div_pkg::op_divu) ?
                         32'hffffffff : dvd[i]);
                wait_done(lat);
                check_value("done latency", lat, 32'd1); // Bypass is one cycle.
            end
        end
        end_test("divide by zero");

        send_req(div_pkg::op_div, 32'h80000000, 32'hffffffff, 32'h80000000);
        wait_done(lat);
        send_req(div_pkg::op_rem, 32'h80000000, 32'hffffffff, 32'h0);
        wait_done(lat);
        send_req(div_pkg::op_divu, 32'd5, 32'd9, 32'h0);
        wait_done(lat);
        send_req(div_pkg::op_remu, 32'd5, 32'd9, 32'd5);
        wait_done(lat);
        send_req(div_pkg::op_rem, 32'hfffffffb, 32'd9, 32'hfffffffb); // -5 rem 9.
        wait_done(lat);
        send_req(div_pkg::op_div, 32'd3, 32'hfffffff9, 32'h0);        // 3 div -7.
        wait_done(lat);
        end_test("overflow and small dividend");

        base_done = done_count;
        send_req(div_pkg::op_divu, 32'hffffffff, 32'h1, 32'hffffffff); // Long run.
        @(posedge clk);
        issue <= 1'b1; // Must be ignored while busy.
        op    <= div_pkg::op_rem;
        rs1   <= 32'd100;
        rs2   <= 32'd7;
        @(posedge clk);
        issue <= 1'b0;
        wait_done(lat);
        repeat (8) @(posedge clk); // Room for a stray done.
        check_value("done count", done_count - base_done, 32'd1);
        end_test("issue while busy");

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- div_quick.f
logic/div_pkg.sv
logic/div_core_if.sv
logic/msb_naive.sv
logic/div_quick_naive.sv
logic/div_sign_ctrl.sv
logic/div_unit.sv
tb/div_unit_sva.sv
tb/div_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the divide unit testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module div_unit_tb -f div_quick.f -o div_unit_sim

output=$(./obj_dir/div_unit_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -q "Simulation passed"; then
    exit 0
fi
exit 1
